// ==== compile.f ====
design/clint_map_pkg.sv
design/clint_types_pkg.sv
design/clint_axil_slave.sv
design/clint_mtime.sv
design/clint_hart_timer.sv
design/clint_read_mux.sv
design/clint_top.sv
tests/clint_properties.sv
tests/clint_tb.sv

// ==== Makefile ====
# Verilator build and run for the CLINT timer block
# every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= clint_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: simulate clean

# build, run, then decide pass or fail from the log
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/clint_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module clint_tb
	import clint_map_pkg::*;
();

	localparam int num_harts = 4;
	localparam int cycles_per_entry = 400;
	localparam int op_write = 0;
	localparam int op_read = 1;
	localparam int op_window = 2; // mtime read, compared with the previous one
	localparam int op_irq = 3;
	localparam logic [31:0] mtime_hi_val = 32'h0000_0002;

	typedef struct packed {
		int op;
		logic [31:0] addr;
		logic [31:0] data; // write data, read data or irq vector
		logic [1:0] resp;
		bit rel; // relative to the last mtime read
		int lo_cyc;
		int hi_cyc;
	} entry_t;

	logic clk;
	logic rst_n;
	logic [31:0] awaddr, wdata, araddr, rdata;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [1:0] bresp, rresp;
	logic [num_harts-1:0] timer_irq;

	entry_t stim[$];
	bit stim_ready = 1'b0;
	int cycle = 0;
	int irq_change_cycle = 0;
	int wr_ref_cycle = 0; // cycle where bvalid was first seen
	int rd_ref_cycle = 0;
	logic [num_harts-1:0] irq_prev = '0;
	logic [31:0] lfsr = 32'h6a6b0c81;
	logic [31:0] last_mtime = '0;
	int last_mtime_cycle = 0;
	int data_errs = 0;
	int resp_errs = 0;
	int irq_errs = 0;

	clint_top #(.NUM_HARTS(num_harts)) UUT (
		.clk, .rst_n,
		.awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.timer_irq
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// cycle count and irq edges, sampled mid-cycle
	initial forever begin
		@(negedge clk);
		if (timer_irq !== irq_prev) begin
			irq_change_cycle = cycle;
			irq_prev = timer_irq;
		end
		cycle = cycle + 1;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_random(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr); // one step per bit
			v = (v << 1) | int'(lfsr[0]);
		end
	endtask

	function automatic logic [31:0] cmp_addr(input int h, input bit hi);
		return {16'h0, mtimecmp_base} + 32'(h * hart_stride) + (hi ? 32'd4 : 32'd0);
	endfunction

	function automatic logic [31:0] lo_pattern(input int h);
		return 32'hc0de_0000 | 32'(h);
	endfunction

	function automatic logic [31:0] hi_pattern(input int h);
		return 32'h8000_0000 | (32'(h) << 8);
	endfunction

	function automatic void add_entry(input int op, input logic [31:0] addr,
			input logic [31:0] data, input logic [1:0] resp, input bit rel,
			input int lo_cyc, input int hi_cyc);
		entry_t e;
		e.op = op;
		e.addr = addr;
		e.data = data;
		e.resp = resp;
		e.rel = rel;
		e.lo_cyc = lo_cyc;
		e.hi_cyc = hi_cyc;
		stim.push_back(e);
	endfunction

	function automatic void build_stim();
		// reset state of every compare half
		for (int h = 0; h < num_harts; h++) begin
			add_entry(op_read, cmp_addr(h, 1'b0), '1, resp_okay, 1'b0, 0, 0);
			add_entry(op_read, cmp_addr(h, 1'b1), '1, resp_okay, 1'b0, 0, 0);
		end
		add_entry(op_read, 32'h1000_4000, '1, resp_okay, 1'b0, 0, 0); // upper bits ignored
		add_entry(op_irq, 32'h0, 32'h0, resp_okay, 1'b0, 0, 4);
		// one half of one hart, neighbours untouched
		add_entry(op_write, cmp_addr(0, 1'b0), lo_pattern(0), resp_okay, 1'b0, 0, 0);
		add_entry(op_read, cmp_addr(0, 1'b0), lo_pattern(0), resp_okay, 1'b0, 0, 0);
		add_entry(op_read, cmp_addr(0, 1'b1), '1, resp_okay, 1'b0, 0, 0);
		add_entry(op_read, cmp_addr(1, 1'b0), '1, resp_okay, 1'b0, 0, 0);
		add_entry(op_write, cmp_addr(0, 1'b1), hi_pattern(0), resp_okay, 1'b0, 0, 0);
		for (int h = 1; h < num_harts; h++) begin
			add_entry(op_write, cmp_addr(h, 1'b0), lo_pattern(h), resp_okay, 1'b0, 0, 0);
			add_entry(op_write, cmp_addr(h, 1'b1), hi_pattern(h), resp_okay, 1'b0, 0, 0);
		end
		for (int h = 0; h < num_harts; h++) begin
			add_entry(op_read, cmp_addr(h, 1'b0), lo_pattern(h), resp_okay, 1'b0, 0, 0);
			add_entry(op_read, cmp_addr(h, 1'b1), hi_pattern(h), resp_okay, 1'b0, 0, 0);
		end
		// hart 1 compare at zero, then back to all ones
		add_entry(op_write, cmp_addr(1, 1'b1), 32'h0, resp_okay, 1'b0, 0, 0);
		add_entry(op_write, cmp_addr(1, 1'b0), 32'h0, resp_okay, 1'b0, 0, 0);
		add_entry(op_irq, 32'h0, 32'h2, resp_okay, 1'b0, 0, 4);
		add_entry(op_write, cmp_addr(1, 1'b1), '1, resp_okay, 1'b0, 0, 0);
		add_entry(op_irq, 32'h0, 32'h0, resp_okay, 1'b0, 0, 4);
		add_entry(op_write, cmp_addr(1, 1'b0), '1, resp_okay, 1'b0, 0, 0);
		add_entry(op_read, cmp_addr(1, 1'b0), '1, resp_okay, 1'b0, 0, 0);
		add_entry(op_read, cmp_addr(0, 1'b0), lo_pattern(0), resp_okay, 1'b0, 0, 0);
		// unmapped offsets
		add_entry(op_read, 32'h0000_8000, 32'h0, resp_slverr, 1'b0, 0, 0);
		add_entry(op_read, 32'h0000_4020, 32'h0, resp_slverr, 1'b0, 0, 0);
		add_entry(op_read, 32'h0000_4002, 32'h0, resp_slverr, 1'b0, 0, 0);
		add_entry(op_write, 32'h0000_4020, 32'h0, resp_slverr, 1'b0, 0, 0);
		add_entry(op_write, 32'h0000_4001, 32'h0, resp_slverr, 1'b0, 0, 0);
		add_entry(op_write, 32'h0000_0000, 32'h0, resp_slverr, 1'b0, 0, 0);
		add_entry(op_read, cmp_addr(0, 1'b0), lo_pattern(0), resp_okay, 1'b0, 0, 0);
		add_entry(op_read, cmp_addr(0, 1'b1), hi_pattern(0), resp_okay, 1'b0, 0, 0);
		add_entry(op_read, cmp_addr(3, 1'b1), hi_pattern(3), resp_okay, 1'b0, 0, 0);
		// mtime runs, then a high-half load
		add_entry(op_window, {16'h0, mtime_lo_addr}, 32'h0, resp_okay, 1'b0, 0, 0);
		add_entry(op_window, {16'h0, mtime_lo_addr}, 32'h0, resp_okay, 1'b1, 0, 0);
		add_entry(op_write, {16'h0, mtime_hi_addr}, mtime_hi_val, resp_okay, 1'b0, 0, 0);
		add_entry(op_read, {16'h0, mtime_hi_addr}, mtime_hi_val, resp_okay, 1'b0, 0, 0);
		// hart 2 fires 300 ticks after the mtime read
		add_entry(op_window, {16'h0, mtime_lo_addr}, 32'h0, resp_okay, 1'b0, 0, 0);
		add_entry(op_write, cmp_addr(2, 1'b1), mtime_hi_val, resp_okay, 1'b0, 0, 0);
		add_entry(op_write, cmp_addr(2, 1'b0), 32'd300, resp_okay, 1'b1, 0, 0);
		add_entry(op_irq, 32'h0, 32'h4, resp_okay, 1'b1, 250, 349);
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int stall;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		while (awready !== 1'b1 || wready !== 1'b1)
			next_cycle();
		next_cycle(); // taken at this edge
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (bvalid !== 1'b1)
			next_cycle();
		wr_ref_cycle = cycle;
		take_random(2, stall);
		repeat (stall) next_cycle();
		resp = bresp;
		bready = 1'b1;
		next_cycle();
		bready = 1'b0;
	endtask

	task automatic read_word(input logic [31:0] addr, output logic [31:0] data,
			output logic [1:0] resp, output int hs_cycle);
		int stall;
		araddr = addr;
		arvalid = 1'b1;
		while (arready !== 1'b1)
			next_cycle();
		hs_cycle = cycle;
		next_cycle();
		arvalid = 1'b0;
		while (rvalid !== 1'b1)
			next_cycle();
		take_random(2, stall);
		repeat (stall) next_cycle();
		data = rdata;
		resp = rresp;
		rready = 1'b1;
		next_cycle();
		rready = 1'b0;
	endtask

	task automatic wait_irq(input logic [num_harts-1:0] exp, input int lo_cyc,
			input int hi_cyc, input bit from_read);
		int ref_cyc;
		int elapsed;
		ref_cyc = from_read ? rd_ref_cycle : wr_ref_cycle;
		while (timer_irq !== exp && (cycle - ref_cyc) <= hi_cyc)
			next_cycle();
		if (timer_irq !== exp) begin
			irq_errs++;
			$display("[FAIL] %0t: timer_irq %b, expected %b", $time, timer_irq, exp);
		end else begin
			next_cycle(); // past the negedge, so the monitor has logged the edge
			elapsed = irq_change_cycle - ref_cyc;
			if (elapsed < lo_cyc || elapsed > hi_cyc) begin
				irq_errs++;
				$display("[FAIL] %0t: timer_irq reached %b after %0d cycles, expected %0d to %0d",
					$time, exp, elapsed, lo_cyc, hi_cyc);
			end
		end
	endtask

	initial begin
		entry_t e;
		logic [31:0] rd;
		logic [31:0] wdat;
		logic [1:0] resp;
		int hs;
		int asrt_errs;
		rst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		build_stim();
		stim_ready = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		next_cycle();
		if (timer_irq !== '0) begin
			irq_errs++;
			$display("[FAIL] %0t: timer_irq %b after reset", $time, timer_irq);
		end
		foreach (stim[i]) begin
			e = stim[i];
			case (e.op)
				op_write: begin
					wdat = e.rel ? last_mtime + e.data : e.data;
					write_word(e.addr, wdat, resp);
					if (resp !== e.resp) begin
						resp_errs++;
						$display("[FAIL] %0t: write 0x%08h response %0d, expected %0d",
							$time, e.addr, resp, e.resp);
					end
				end
				op_read, op_window: begin
					read_word(e.addr, rd, resp, hs);
					if (resp !== e.resp) begin
						resp_errs++;
						$display("[FAIL] %0t: read 0x%08h response %0d, expected %0d",
							$time, e.addr, resp, e.resp);
					end
					if (e.op == op_read && rd !== e.data) begin
						data_errs++;
						$display("[FAIL] %0t: read 0x%08h returned 0x%08h, expected 0x%08h",
							$time, e.addr, rd, e.data);
					end
					if (e.op == op_window && e.rel
							&& (rd - last_mtime) < 32'(hs - last_mtime_cycle)) begin
						data_errs++;
						$display("[FAIL] %0t: mtime advanced by %0d over %0d cycles",
							$time, rd - last_mtime, hs - last_mtime_cycle);
					end
					if (e.op == op_window) begin
						last_mtime = rd;
						last_mtime_cycle = hs;
						rd_ref_cycle = hs;
					end
				end
				op_irq: wait_irq(e.data[num_harts-1:0], e.lo_cyc, e.hi_cyc, e.rel);
				default: begin
					data_errs++;
					$display("unknown table operation %0d at entry %0d", e.op, i);
				end
			endcase
		end
		asrt_errs = int'(UUT.u_properties.fail_count);
		$display("errors: data %0d, response %0d, irq %0d, assertion %0d",
			data_errs, resp_errs, irq_errs, asrt_errs);
		if (data_errs + resp_errs + irq_errs + asrt_errs == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	// watchdog, sized from the table length
	initial begin
		wait (stim_ready);
		repeat (stim.size() * cycles_per_entry + 2000) @(posedge clk);
		$display("timed out: the bus transactions did not finish in time");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/clint_properties.sv ====
`default_nettype none
`timescale 1ns/1ps

module clint_properties (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic awvalid,
	input wire logic wvalid,
	input wire logic awready,
	input wire logic wready,
	input wire logic bvalid,
	input wire logic bready,
	input wire logic rvalid,
	input wire logic rready
);

	int unsigned fail_count = 0; // assertion failures so far

	// responses stay up until the master takes them
	a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid)
		else begin
			$error("bvalid dropped before bready");
			fail_count++;
		end

	a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid)
		else begin
			$error("rvalid dropped before rready");
			fail_count++;
		end

	// accept needs address and data together, no response pending
	a_aw_with_w: assert property (@(posedge clk) disable iff (!rst_n)
		awready || wready |-> awready && wready && awvalid && wvalid && !bvalid)
		else begin
			$error("write accepted without address and data together, or with bvalid high");
			fail_count++;
		end

	// first cycle out of reset
	a_resp_reset: assert property (@(posedge clk) $rose(rst_n) |-> !bvalid && !rvalid)
		else begin
			$error("response valid in the first cycle after reset");
			fail_count++;
		end

endmodule

bind clint_top clint_properties u_properties (
	.clk(clk),
	.rst_n(rst_n),
	.awvalid(awvalid),
	.wvalid(wvalid),
	.awready(awready),
	.wready(wready),
	.bvalid(bvalid),
	.bready(bready),
	.rvalid(rvalid),
	.rready(rready)
);

`default_nettype wire

// ==== design/clint_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module clint_top
	import clint_types_pkg::*;
#(
	parameter int NUM_HARTS = 4 // 1 to 16
) (
	input  wire logic clk,
	input  wire logic rst_n,

	input  wire logic [31:0] awaddr,
	input  wire logic awvalid,
	output logic awready,
	input  wire logic [31:0] wdata,
	input  wire logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  wire logic bready,

	input  wire logic [31:0] araddr,
	input  wire logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input  wire logic rready,

	output logic [NUM_HARTS-1:0] timer_irq
);

	localparam int HART_IDX_W = $clog2(NUM_HARTS + 1);

	logic [bus_w-1:0] wr_data;
	logic wr_hi;
	logic mtime_we;
	logic [NUM_HARTS-1:0] hart_we;
	logic rd_req;
	logic rd_sel_mtime;
	logic [HART_IDX_W-1:0] rd_hart;
	logic rd_hi;
	reg64_u mtime;
	reg64_u [NUM_HARTS-1:0] mtimecmp_all;

	clint_axil_slave #(.NUM_HARTS(NUM_HARTS), .HART_IDX_W(HART_IDX_W)) u_slave (
		.clk, .rst_n,
		.awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rvalid, .rresp, .rready,
		.wr_data, .wr_hi, .mtime_we, .hart_we,
		.rd_req, .rd_sel_mtime, .rd_hart, .rd_hi
	);

	clint_mtime u_mtime (
		.clk, .rst_n, .mtime_we, .wr_hi, .wr_data, .mtime
	);

	for (genvar h = 0; h < NUM_HARTS; h++) begin : g_hart
		clint_hart_timer u_timer (
			.clk, .rst_n,
			.we(hart_we[h]),
			.wr_hi, .wr_data, .mtime,
			.mtimecmp(mtimecmp_all[h]),
			.irq(timer_irq[h])
		);
	end

	clint_read_mux #(.NUM_HARTS(NUM_HARTS), .HART_IDX_W(HART_IDX_W)) u_read_mux (
		.clk, .rst_n, .rd_req, .rd_sel_mtime, .rd_hart, .rd_hi,
		.mtime, .mtimecmp_all, .rdata
	);

endmodule

`default_nettype wire

// ==== design/clint_read_mux.sv ====
`default_nettype none
`timescale 1ns/1ps

module clint_read_mux
	import clint_types_pkg::*;
#(
	parameter int NUM_HARTS = 4,
	parameter int HART_IDX_W = $clog2(NUM_HARTS + 1)
) (
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic rd_req,
	input  wire logic rd_sel_mtime,
	input  wire logic [HART_IDX_W-1:0] rd_hart,
	input  wire logic rd_hi,
	input  wire reg64_u mtime,
	input  wire reg64_u [NUM_HARTS-1:0] mtimecmp_all,
	output logic [bus_w-1:0] rdata
);

	reg64_u cmp_sel;
	logic hart_hit; // low when rd_hart holds the no-hart code

	always_comb begin
		cmp_sel = '0;
		hart_hit = 1'b0;
		for (int h = 0; h < NUM_HARTS; h++) begin
			if (rd_hart == HART_IDX_W'(h)) begin
				cmp_sel = mtimecmp_all[h];
				hart_hit = 1'b1;
			end
		end
	end

	// captured on rd_req, held until the next request
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (rd_req) begin
			if (rd_sel_mtime)
				rdata <= rd_hi ? mtime.half.hi : mtime.half.lo;
			else if (hart_hit)
				rdata <= rd_hi ? cmp_sel.half.hi : cmp_sel.half.lo;
			else
				rdata <= '0; // unmapped offset
		end
	end

endmodule

`default_nettype wire

// ==== design/clint_hart_timer.sv ====
`default_nettype none
`timescale 1ns/1ps

module clint_hart_timer
	import clint_types_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic we,
	input  wire logic wr_hi,
	input  wire logic [bus_w-1:0] wr_data,
	input  wire reg64_u mtime,
	output reg64_u mtimecmp,
	output logic irq
);

	// compare register, one half per write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtimecmp.word <= mtimecmp_reset;
		end else if (we) begin
			if (wr_hi)
				mtimecmp.half.hi <= wr_data;
			else
				mtimecmp.half.lo <= wr_data;
		end
	end

	// level interrupt, lags the registers by one cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			irq <= 1'b0;
		else
			irq <= (mtime.word >= mtimecmp.word); // unsigned compare
	end

endmodule

`default_nettype wire

// ==== design/clint_mtime.sv ====
`default_nettype none
`timescale 1ns/1ps

module clint_mtime
	import clint_types_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst_n,
	input  wire logic mtime_we,
	input  wire logic wr_hi,
	input  wire logic [bus_w-1:0] wr_data,
	output reg64_u mtime
);

	// counts every clock, no separate tick

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime.word <= '0;
		end else if (mtime_we) begin
			// software load, other half kept and no increment
			if (wr_hi)
				mtime.half.hi <= wr_data;
			else
				mtime.half.lo <= wr_data;
		end else begin
			mtime.word <= mtime.word + reg_w'(1);
		end
	end

endmodule

`default_nettype wire

// ==== design/clint_axil_slave.sv ====
`default_nettype none
`timescale 1ns/1ps

module clint_axil_slave
	import clint_map_pkg::*;
	import clint_types_pkg::*;
#(
	parameter int NUM_HARTS = 4,
	// one spare code, index NUM_HARTS means no hart
	parameter int HART_IDX_W = $clog2(NUM_HARTS + 1)
) (
	input  wire logic clk,
	input  wire logic rst_n,

	input  wire logic [31:0] awaddr,
	input  wire logic awvalid,
	output logic awready,
	input  wire logic [31:0] wdata,
	input  wire logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input  wire logic bready,

	input  wire logic [31:0] araddr,
	input  wire logic arvalid,
	output logic arready,
	output logic rvalid,
	output logic [1:0] rresp,
	input  wire logic rready,

	output logic [bus_w-1:0] wr_data,
	output logic wr_hi,
	output logic mtime_we,
	output logic [NUM_HARTS-1:0] hart_we,
	output logic rd_req,
	output logic rd_sel_mtime,
	output logic [HART_IDX_W-1:0] rd_hart,
	output logic rd_hi
);

	logic wr_ready_q; // one-cycle accept pulse, cycle T
	logic [offset_bits-1:0] wr_off;
	logic [offset_bits-1:0] rd_off;
	logic wr_map_mtime;
	logic wr_map_hart;
	logic rd_map_mtime;
	logic rd_map_hart;

	function automatic logic is_mtime(input logic [offset_bits-1:0] off);
		return (off == mtime_lo_addr) || (off == mtime_hi_addr);
	endfunction

	// inside the mtimecmp window and word aligned
	function automatic logic is_hart(input logic [offset_bits-1:0] off);
		logic [offset_bits-1:0] rel;
		rel = off - mtimecmp_base;
		return (off >= mtimecmp_base) && (rel < offset_bits'(NUM_HARTS * hart_stride))
			&& (off[1:0] == 2'b00);
	endfunction

	function automatic logic [HART_IDX_W-1:0] hart_of(input logic [offset_bits-1:0] off);
		logic [offset_bits-1:0] rel;
		rel = off - mtimecmp_base;
		return HART_IDX_W'(rel / offset_bits'(hart_stride));
	endfunction

	assign wr_off = awaddr[offset_bits-1:0];
	assign rd_off = araddr[offset_bits-1:0];
	assign wr_map_mtime = is_mtime(wr_off);
	assign wr_map_hart = is_hart(wr_off);
	assign rd_map_mtime = is_mtime(rd_off);
	assign rd_map_hart = is_hart(rd_off);

	// address and data are taken together
	assign awready = wr_ready_q;
	assign wready = wr_ready_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ready_q <= 1'b0;
			bvalid <= 1'b0;
			bresp <= resp_okay;
			mtime_we <= 1'b0;
			hart_we <= '0;
		end else begin
			wr_ready_q <= awvalid && wvalid && !bvalid && !wr_ready_q;
			mtime_we <= 1'b0; // strobes last one cycle
			hart_we <= '0;
			if (wr_ready_q) begin
				bvalid <= 1'b1;
				mtime_we <= wr_map_mtime;
				hart_we <= wr_map_hart ? (NUM_HARTS'(1) << hart_of(wr_off)) : '0;
				bresp <= (wr_map_mtime || wr_map_hart) ? resp_okay : resp_slverr;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// write payload toward the targets
	always_ff @(posedge clk) begin
		if (wr_ready_q) begin
			wr_data <= wdata;
			wr_hi <= awaddr[2];
		end
	end

	// read side, arready in R, rd_req in R+1, rvalid from R+2
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rd_req <= 1'b0;
			rvalid <= 1'b0;
			rresp <= resp_okay;
			rd_sel_mtime <= 1'b0;
			rd_hart <= HART_IDX_W'(NUM_HARTS);
			rd_hi <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rd_req && !rvalid;
			rd_req <= arready;
			if (arready) begin
				rd_sel_mtime <= rd_map_mtime;
				rd_hart <= rd_map_hart ? hart_of(rd_off) : HART_IDX_W'(NUM_HARTS);
				rd_hi <= araddr[2];
				rresp <= (rd_map_mtime || rd_map_hart) ? resp_okay : resp_slverr;
			end
			if (rd_req)
				rvalid <= 1'b1; // mux captures in the same edge
			else if (rready)
				rvalid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== design/clint_types_pkg.sv ====
`default_nettype none

package clint_types_pkg;

	localparam int bus_w = 32;
	localparam int reg_w = 64;

	// whole word for counting and compare, halves for bus access
	typedef union packed {
		logic [reg_w-1:0] word;
		struct packed {
			logic [bus_w-1:0] hi;
			logic [bus_w-1:0] lo;
		} half;
	} reg64_u;

	// compare never matches out of reset
	localparam logic [reg_w-1:0] mtimecmp_reset = '1;

endpackage

`default_nettype wire

// ==== design/clint_map_pkg.sv ====
`default_nettype none

package clint_map_pkg;

	// hart 0 mtimecmp low half, the rest follow at hart_stride
	localparam logic [15:0] mtimecmp_base = 16'h4000;
	localparam int hart_stride = 8;

	// shared counter, one word per half
	localparam logic [15:0] mtime_lo_addr = 16'hbff8;
	localparam logic [15:0] mtime_hi_addr = 16'hbffc;

	// address bits above this are ignored
	localparam int offset_bits = 16;

	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire
